/* logic/lsu_pkg.sv */
// LSU shared definitions
package lsu_pkg;

   localparam int LSU_AW = 32;   // Address width
   localparam int LSU_DW = 32;   // Data width

   // Access size code, 0 is illegal
   typedef logic [2:0] lsu_size_t;

   localparam lsu_size_t SIZE_BYTE = 3'd1;
   localparam lsu_size_t SIZE_HALF = 3'd2;
   localparam lsu_size_t SIZE_WORD = 3'd3;

   // One data word, seen whole or as byte lanes
   typedef union packed {
      logic [LSU_DW-1:0] word;
      logic [3:0][7:0]   lanes;   // Lane 0 is least significant
   } lsu_word_u;

   // Bytes moved by one access, zero for an illegal code
   function automatic logic [2:0] size_bytes(lsu_size_t size);
      case (size)
         SIZE_BYTE: size_bytes = 3'd1;
         SIZE_HALF: size_bytes = 3'd2;
         SIZE_WORD: size_bytes = 3'd4;
         default:   size_bytes = 3'd0;
      endcase
   endfunction

endpackage

/* logic/mem_cmd_if.sv */
// LSU channel interfaces
`timescale 1ns/10ps

// Sized command into the SRAM
interface mem_cmd_if import lsu_pkg::*; ();
   logic              valid;
   logic              ready;
   logic              we;
   lsu_size_t         size;
   logic [LSU_AW-1:0] addr;
   logic [LSU_DW-1:0] wdata;

   modport master (output valid, we, size, addr, wdata, input ready);
   modport slave  (input valid, we, size, addr, wdata, output ready);
endinterface

// Raw SRAM answer, stores answer too
interface mem_rsp_if import lsu_pkg::*; ();
   logic              valid;
   logic              ready;
   logic [LSU_DW-1:0] rdata;

   modport master (output valid, rdata, input ready);
   modport slave  (input valid, rdata, output ready);
endinterface

// Shape of the response that is pending
interface lsu_ctl_if import lsu_pkg::*; ();
   logic      set;    // One cycle per accepted request
   logic      err;
   logic      load;
   logic      sign;
   lsu_size_t size;

   modport master (output set, err, load, sign, size);
   modport slave  (input set, err, load, sign, size);
endinterface

/* logic/lsu_issue.sv */
// LSU request issue
`timescale 1ns/10ps

module lsu_issue
   import lsu_pkg::*;
#(
   parameter int MEM_BYTES = 1024
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              req_valid,
   output logic              req_ready,
   input  logic              req_we,
   input  lsu_size_t         req_size,
   input  logic              req_signed,
   input  logic [LSU_AW-1:0] req_addr,
   input  logic [LSU_DW-1:0] req_wdata,
   input  logic              done,
   mem_cmd_if.master         cmd,
   lsu_ctl_if.master         ctl
);

   logic            busy;
   logic            busy_nxt;
   logic            accept;
   logic            aligned;
   logic            legal;
   logic [2:0]      nbytes;
   logic [LSU_AW:0] end_addr;

   assign accept = req_valid & req_ready;

   // Legality of the request on the port
   always_comb begin
      nbytes   = size_bytes(req_size);
      end_addr = {1'b0, req_addr} + (LSU_AW+1)'(nbytes);   // One past the last byte
      case (req_size)
         SIZE_HALF: aligned = ~req_addr[0];
         SIZE_WORD: aligned = req_addr[1:0] == 2'b00;
         default:   aligned = 1'b1;
      endcase
      legal = (nbytes != 3'd0) && aligned && (end_addr <= (LSU_AW+1)'(MEM_BYTES));
   end

   // Busy from acceptance until the core takes the response
   always_comb begin
      busy_nxt = busy;
      if (accept)
         busy_nxt = 1'b1;
      else if (done)
         busy_nxt = 1'b0;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         busy      <= 1'b0;
         req_ready <= 1'b0;
         cmd.valid <= 1'b0;
         ctl.set   <= 1'b0;
      end else begin
         busy      <= busy_nxt;
         req_ready <= ~busy_nxt;
         ctl.set   <= accept;
         if (accept)
            cmd.valid <= legal;   // Illegal requests never reach the SRAM
         else if (cmd.ready)
            cmd.valid <= 1'b0;
      end
   end

   // Command and response shape, held until used
   always_ff @(posedge clk) begin
      if (accept) begin
         cmd.we    <= req_we;
         cmd.size  <= req_size;
         cmd.addr  <= req_addr;
         cmd.wdata <= req_wdata;
         ctl.err   <= ~legal;
         ctl.load  <= ~req_we;
         ctl.sign  <= req_signed;
         ctl.size  <= req_size;
      end
   end

endmodule

/* logic/lsu_align.sv */
// LSU response alignment
`timescale 1ns/10ps

module lsu_align
   import lsu_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   lsu_ctl_if.slave          ctl,
   mem_rsp_if.slave          mem,
   output logic              rsp_valid,
   input  logic              rsp_ready,
   output logic [LSU_DW-1:0] rsp_rdata,
   output logic              rsp_err,
   output logic              done
);

   logic              wait_mem;
   logic              mem_xfer;
   logic              load_q;
   logic              sign_q;
   lsu_size_t         size_q;
   lsu_word_u         raw;
   logic [LSU_DW-1:0] ext;

   assign mem.ready = wait_mem;
   assign mem_xfer  = mem.valid & mem.ready;
   assign done      = rsp_valid & rsp_ready;

   // Extension of the raw SRAM word
   always_comb begin
      raw.word = mem.rdata;
      ext      = '0;   // Stores return zero
      if (load_q) begin
         case (size_q)
            SIZE_BYTE: ext = {{(LSU_DW-8){sign_q & raw.lanes[0][7]}}, raw.lanes[0]};
            SIZE_HALF: ext = {{(LSU_DW-16){sign_q & raw.lanes[1][7]}}, raw.word[15:0]};
            default:   ext = raw.word;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wait_mem  <= 1'b0;
         rsp_valid <= 1'b0;
         rsp_err   <= 1'b0;
      end else if (ctl.set) begin
         wait_mem  <= ~ctl.err;
         rsp_valid <= ctl.err;   // Error answers at once
         rsp_err   <= ctl.err;
      end else if (mem_xfer) begin
         wait_mem  <= 1'b0;
         rsp_valid <= 1'b1;
      end else if (done) begin
         rsp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (ctl.set) begin
         load_q <= ctl.load;
         sign_q <= ctl.sign;
         size_q <= ctl.size;
      end
      if (ctl.set & ctl.err)
         rsp_rdata <= '0;
      else if (mem_xfer)
         rsp_rdata <= ext;
   end

endmodule

/* logic/cmd_sram.sv */
// Byte-addressed command SRAM
`timescale 1ns/10ps

module cmd_sram
   import lsu_pkg::*;
#(
   parameter int MEM_BYTES = 1024,
   parameter int DELAY     = 3
) (
   input  logic      clk,
   input  logic      reset,
   mem_cmd_if.slave  cmd,
   mem_rsp_if.master rsp
);

   localparam int AI = (MEM_BYTES > 1) ? $clog2(MEM_BYTES) : 1;   // Byte index width
   localparam int CW = $clog2(DELAY + 1);

   logic [7:0]    mem [MEM_BYTES];
   logic          busy;
   logic [CW-1:0] cnt;
   logic          push;
   logic          pop;
   logic          fire;
   logic          we_q;
   lsu_size_t     size_q;
   logic [AI-1:0] base_q;
   lsu_word_u     wdata_q;
   lsu_word_u     rd;
   logic [2:0]    nbytes;

   initial begin
      for (int i = 0; i < MEM_BYTES; i++)
         mem[i] = 8'h00;
   end

   assign push      = cmd.valid & cmd.ready;
   assign pop       = rsp.valid & rsp.ready;
   assign cmd.ready = ~busy;
   assign rsp.valid = cnt == CW'(DELAY);
   assign fire      = busy && (cnt == CW'(DELAY - 1));   // Memory acts on this edge
   assign nbytes    = size_bytes(size_q);

   // Stage counter, 1 to DELAY after acceptance
   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= 1'b0;
         cnt  <= '0;
      end else if (push) begin
         busy <= 1'b1;
      end else if (pop) begin
         busy <= 1'b0;
         cnt  <= '0;
      end else if (busy && cnt != CW'(DELAY)) begin
         cnt <= cnt + CW'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         we_q         <= cmd.we;
         size_q       <= cmd.size;
         base_q       <= cmd.addr[AI-1:0];
         wdata_q.word <= cmd.wdata;
      end
   end

   // Read word, unused upper lanes zero
   always_comb begin
      for (int i = 0; i < 4; i++)
         rd.lanes[i] = (3'(i) < nbytes) ? mem[base_q + AI'(i)] : 8'h00;
   end

   // Little-endian lane writes or read capture
   always @(posedge clk) begin
      if (fire) begin
         if (we_q) begin
            for (int i = 0; i < 4; i++) begin
               if (3'(i) < nbytes)
                  mem[base_q + AI'(i)] <= wdata_q.lanes[i];
            end
         end else begin
            rsp.rdata <= rd.word;
         end
      end
   end

endmodule

/* logic/lsu_top.sv */
// Load/store unit top level
`timescale 1ns/10ps

module lsu_top
   import lsu_pkg::*;
#(
   parameter int MEM_BYTES = 1024,
   parameter int DELAY     = 3
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              req_valid,
   output logic              req_ready,
   input  logic              req_we,
   input  lsu_size_t         req_size,
   input  logic              req_signed,
   input  logic [LSU_AW-1:0] req_addr,
   input  logic [LSU_DW-1:0] req_wdata,
   output logic              rsp_valid,
   input  logic              rsp_ready,
   output logic [LSU_DW-1:0] rsp_rdata,
   output logic              rsp_err
);

   logic done;   // Core took the response

   mem_cmd_if cmd_bus ();
   mem_rsp_if rsp_bus ();
   lsu_ctl_if ctl_bus ();

   lsu_issue #(
      .MEM_BYTES (MEM_BYTES)
   ) u_issue (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req_we     (req_we),
      .req_size   (req_size),
      .req_signed (req_signed),
      .req_addr   (req_addr),
      .req_wdata  (req_wdata),
      .done       (done),
      .cmd        (cmd_bus.master),
      .ctl        (ctl_bus.master)
   );

   lsu_align u_align (
      .clk       (clk),
      .reset     (reset),
      .ctl       (ctl_bus.slave),
      .mem       (rsp_bus.slave),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_rdata (rsp_rdata),
      .rsp_err   (rsp_err),
      .done      (done)
   );

   cmd_sram #(
      .MEM_BYTES (MEM_BYTES),
      .DELAY     (DELAY)
   ) u_sram (
      .clk   (clk),
      .reset (reset),
      .cmd   (cmd_bus.slave),
      .rsp   (rsp_bus.master)
   );

endmodule

/* tb/lsu_props.sv */
// LSU handshake assertions
`timescale 1ns/10ps

module lsu_props
   import lsu_pkg::*;
(
   input logic              clk,
   input logic              reset,
   input logic              rsp_valid,
   input logic              rsp_ready,
   input logic [LSU_DW-1:0] rsp_rdata,
   input logic              rsp_err,
   input logic              req_ready,
   input logic              busy,
   input logic              cmd_valid
);

   int fails = 0;   // Failed assertion count

   a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_err))
      else begin
         $error("response dropped or changed before rsp_ready");
         fails++;
      end

   a_ready_pending: assert property (@(posedge clk) disable iff (reset)
      rsp_valid |-> !req_ready)
      else begin
         $error("req_ready high while a response is pending");
         fails++;
      end

   a_cmd_busy: assert property (@(posedge clk) disable iff (reset)
      cmd_valid |-> busy)
      else begin
         $error("SRAM command valid with no request in flight");
         fails++;
      end

endmodule

bind lsu_top lsu_props props_i (
   .clk       (clk),
   .reset     (reset),
   .rsp_valid (rsp_valid),
   .rsp_ready (rsp_ready),
   .rsp_rdata (rsp_rdata),
   .rsp_err   (rsp_err),
   .req_ready (req_ready),
   .busy      (u_issue.busy),
   .cmd_valid (cmd_bus.valid)
);

/* tb/lsu_checker.sv */
// LSU response checker
`timescale 1ns/10ps

module lsu_checker
   import lsu_pkg::*;
#(
   parameter int MEM_BYTES = 1024,
   parameter int RSP_LIMIT = 200
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              req_valid,
   input  logic              req_ready,
   input  logic              req_we,
   input  lsu_size_t         req_size,
   input  logic              req_signed,
   input  logic [LSU_AW-1:0] req_addr,
   input  logic [LSU_DW-1:0] req_wdata,
   input  logic              tab_err,     // Table expectation, sampled with the request
   input  logic [LSU_DW-1:0] tab_rdata,
   input  logic              rsp_valid,
   input  logic              rsp_ready,
   input  logic [LSU_DW-1:0] rsp_rdata,
   input  logic              rsp_err,
   output int                mismatches,
   output int                timeouts,
   output int                responses
);

   localparam int AI = (MEM_BYTES > 1) ? $clog2(MEM_BYTES) : 1;

   logic [7:0]      model [MEM_BYTES];   // Byte memory seen by the core
   logic [LSU_DW:0] model_q [$];         // {err, rdata} per accepted request
   logic [LSU_DW:0] table_q [$];
   int              idle;

   task automatic compare_value(input string sig, input logic [LSU_DW-1:0] exp,
                                input logic [LSU_DW-1:0] got);
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH t=%0t %s expected=%h got=%h", $time, sig, exp, got);
      end
   endtask

   always @(posedge clk) begin
      int                n;
      logic              ok;
      logic [AI-1:0]     base;
      logic [LSU_DW-1:0] val;
      logic [LSU_DW:0]   exp;
      logic [LSU_DW:0]   tab;
      if (reset) begin
         for (int i = 0; i < MEM_BYTES; i++)
            model[AI'(i)] = 8'h00;
         model_q.delete();
         table_q.delete();
         idle       = 0;
         mismatches = 0;
         timeouts   = 0;
         responses  = 0;
      end else begin
         if (rsp_valid && rsp_ready) begin
            responses++;
            idle = 0;
            if (model_q.size() == 0) begin
               mismatches++;
               $display("Response at t=%0t arrived with no request pending", $time);
            end else begin
               exp = model_q.pop_front();
               tab = table_q.pop_front();
               compare_value("rsp_err", LSU_DW'(exp[LSU_DW]), LSU_DW'(rsp_err));
               compare_value("rsp_rdata", exp[LSU_DW-1:0], rsp_rdata);
               compare_value("rsp_err(table)", LSU_DW'(tab[LSU_DW]), LSU_DW'(rsp_err));
               compare_value("rsp_rdata(table)", tab[LSU_DW-1:0], rsp_rdata);
            end
         end else if (model_q.size() != 0) begin
            idle++;
            if (idle == RSP_LIMIT) begin
               timeouts++;
               $display("TIMEOUT: no response within %0d cycles at t=%0t", RSP_LIMIT, $time);
            end
         end
         if (req_valid && req_ready) begin
            case (req_size)
               SIZE_BYTE: n = 1;
               SIZE_HALF: n = 2;
               SIZE_WORD: n = 4;
               default:   n = 0;
            endcase
            ok = (n != 0) && ((req_addr[1:0] & 2'(n - 1)) == 2'b00)
                 && (longint'(req_addr) + longint'(n) <= longint'(MEM_BYTES));
            base = req_addr[AI-1:0];
            val  = '0;   // Stores and errors read as zero
            if (ok) begin
               for (int i = 0; i < n; i++) begin
                  if (req_we)
                     model[base + AI'(i)] = req_wdata[8*i +: 8];
                  else
                     val[8*i +: 8] = model[base + AI'(i)];
               end
            end
            if (ok && !req_we) begin
               case (req_size)
                  SIZE_BYTE: val = {{(LSU_DW-8){req_signed & val[7]}}, val[7:0]};
                  SIZE_HALF: val = {{(LSU_DW-16){req_signed & val[15]}}, val[15:0]};
                  default:   ;
               endcase
            end
            model_q.push_back({~ok, val});
            table_q.push_back({tab_err, tab_rdata});
         end
      end
   end

endmodule

/* tb/lsu_tb.sv */
// LSU testbench
`timescale 1ns/10ps

module lsu_tb
   import lsu_pkg::*;
();

   localparam int MEM_BYTES  = 1024;
   localparam int DELAY      = 3;
   localparam int WAIT_LIMIT = 500;
   localparam int NROWS      = 23;

   typedef struct packed {
      logic              we;
      lsu_size_t         size;
      logic              sgn;
      logic [LSU_AW-1:0] addr;
      logic [LSU_DW-1:0] wdata;
      logic              err;     // Expected rsp_err
      logic [LSU_DW-1:0] rdata;   // Expected rsp_rdata
   } row_t;

   // we, size, signed, addr, wdata, expected err, expected rdata
   row_t rows [NROWS] = '{
      '{1'b0, SIZE_WORD, 1'b0, 32'h0000_0100, 32'h0000_0000, 1'b0, 32'h0000_0000},
      '{1'b1, SIZE_WORD, 1'b0, 32'h0000_0010, 32'h1234_5678, 1'b0, 32'h0000_0000},
      '{1'b0, SIZE_WORD, 1'b0, 32'h0000_0010, 32'h0000_0000, 1'b0, 32'h1234_5678},
      '{1'b1, SIZE_WORD, 1'b0, 32'h0000_0020, 32'h8899_AABB, 1'b0, 32'h0000_0000},
      '{1'b1, SIZE_BYTE, 1'b0, 32'h0000_0021, 32'hFFFF_FF5C, 1'b0, 32'h0000_0000},
      '{1'b1, SIZE_HALF, 1'b0, 32'h0000_0022, 32'hFFFF_F00D, 1'b0, 32'h0000_0000},
      '{1'b0, SIZE_WORD, 1'b0, 32'h0000_0020, 32'h0000_0000, 1'b0, 32'hF00D_5CBB},
      '{1'b0, SIZE_BYTE, 1'b1, 32'h0000_0020, 32'h0000_0000, 1'b0, 32'hFFFF_FFBB},
      '{1'b0, SIZE_BYTE, 1'b0, 32'h0000_0020, 32'h0000_0000, 1'b0, 32'h0000_00BB},
      '{1'b0, SIZE_BYTE, 1'b1, 32'h0000_0021, 32'h0000_0000, 1'b0, 32'h0000_005C},
      '{1'b0, SIZE_HALF, 1'b1, 32'h0000_0022, 32'h0000_0000, 1'b0, 32'hFFFF_F00D},
      '{1'b0, SIZE_HALF, 1'b0, 32'h0000_0022, 32'h0000_0000, 1'b0, 32'h0000_F00D},
      '{1'b0, SIZE_HALF, 1'b1, 32'h0000_0010, 32'h0000_0000, 1'b0, 32'h0000_5678},
      '{1'b1, 3'd0,      1'b0, 32'h0000_0010, 32'hDEAD_BEEF, 1'b1, 32'h0000_0000},
      '{1'b1, SIZE_HALF, 1'b0, 32'h0000_0011, 32'hDEAD_BEEF, 1'b1, 32'h0000_0000},
      '{1'b1, SIZE_WORD, 1'b0, 32'h0000_0012, 32'hDEAD_BEEF, 1'b1, 32'h0000_0000},
      '{1'b1, SIZE_WORD, 1'b0, 32'h0000_0400, 32'hDEAD_BEEF, 1'b1, 32'h0000_0000},
      '{1'b0, SIZE_WORD, 1'b0, 32'h0000_0013, 32'h0000_0000, 1'b1, 32'h0000_0000},
      '{1'b0, SIZE_WORD, 1'b0, 32'h0000_0010, 32'h0000_0000, 1'b0, 32'h1234_5678},
      '{1'b1, SIZE_WORD, 1'b0, 32'h0000_03FC, 32'hCAFE_F00D, 1'b0, 32'h0000_0000},
      '{1'b0, SIZE_BYTE, 1'b1, 32'h0000_03FF, 32'h0000_0000, 1'b0, 32'hFFFF_FFCA},
      '{1'b0, SIZE_BYTE, 1'b1, 32'h0000_0013, 32'h0000_0000, 1'b0, 32'h0000_0012},
      '{1'b0, SIZE_WORD, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 32'h0000_0000}
   };

   logic              clk;
   logic              reset;
   logic              req_valid;
   logic              req_ready;
   logic              req_we;
   lsu_size_t         req_size;
   logic              req_signed;
   logic [LSU_AW-1:0] req_addr;
   logic [LSU_DW-1:0] req_wdata;
   logic              rsp_valid;
   logic              rsp_ready;
   logic [LSU_DW-1:0] rsp_rdata;
   logic              rsp_err;
   logic              tab_err;
   logic [LSU_DW-1:0] tab_rdata;
   int                mismatches;
   int                timeouts;
   int                responses;
   int                waits_lost;
   integer            seed;
   integer            rnd;

   lsu_top #(.MEM_BYTES(MEM_BYTES), .DELAY(DELAY)) dut_i (.*);

   lsu_checker #(.MEM_BYTES(MEM_BYTES)) chk_i (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Random back-pressure on the response
   initial begin
      seed      = 57;
      rsp_ready = 1'b0;
      forever begin
         @(negedge clk);
         rnd       = $random(seed);
         rsp_ready = ~reset & (rnd[1:0] != 2'b00);
      end
   end

   task automatic send_row(input row_t row);
      int waited;
      waited = 0;
      @(negedge clk);
      while (!req_ready && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!req_ready) begin
         waits_lost++;
         $display("TIMEOUT: req_ready stayed low for %0d cycles", WAIT_LIMIT);
      end else begin
         req_we     = row.we;
         req_size   = row.size;
         req_signed = row.sgn;
         req_addr   = row.addr;
         req_wdata  = row.wdata;
         tab_err    = row.err;
         tab_rdata  = row.rdata;
         req_valid  = 1'b1;
         @(negedge clk);
         req_valid = 1'b0;
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (responses < NROWS && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (responses < NROWS) begin
         waits_lost++;
         $display("TIMEOUT: only %0d of %0d responses arrived", responses, NROWS);
      end
   endtask

   initial begin
      reset      = 1'b1;
      req_valid  = 1'b0;
      req_we     = 1'b0;
      req_size   = '0;
      req_signed = 1'b0;
      req_addr   = '0;
      req_wdata  = '0;
      tab_err    = 1'b0;
      tab_rdata  = '0;
      waits_lost = 0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      for (int i = 0; i < NROWS && waits_lost == 0; i++)
         send_row(rows[i]);
      wait_drain();
      $display("errors: mismatch=%0d timeout=%0d wait_timeout=%0d assert=%0d responses=%0d of %0d",
               mismatches, timeouts, waits_lost, dut_i.props_i.fails, responses, NROWS);
      if (mismatches == 0 && timeouts == 0 && waits_lost == 0 &&
          dut_i.props_i.fails == 0 && responses == NROWS)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* files.f */
logic/lsu_pkg.sv
logic/mem_cmd_if.sv
logic/lsu_issue.sv
logic/lsu_align.sv
logic/cmd_sram.sv
logic/lsu_top.sv
tb/lsu_props.sv
tb/lsu_checker.sv
tb/lsu_tb.sv

/* Makefile */
# Verilator build for the LSU testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
